/* Makefile */
SIM := obj_dir/Vtb_rv32c_decoder

.PHONY: all run clean

all: run

$(SIM): rv32c_decoder.f $(wildcard logic/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing --assert -f rv32c_decoder.f \
		--top-module tb_rv32c_decoder -Mdir obj_dir

run: $(SIM)
	./$(SIM) +verilator+error+limit+100 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Simulation failed" sim.log; then echo "run failed"; exit 1; fi
	@grep -q "Simulation completed successfully" sim.log || \
		(echo "run ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* logic/decode_reg.sv */
module decode_reg import rv_decode_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ins_valid,
    input  logic                  is_compressed_d,
    input  op_e                   op_d,
    input  logic [REG_ADDR_W-1:0] rd_d,
    input  logic [REG_ADDR_W-1:0] rs1_d,
    input  logic [REG_ADDR_W-1:0] rs2_d,
    input  logic [XLEN-1:0]       imm_d,
    input  logic                  jump_en_d,
    input  logic [XLEN-1:0]       jump_offset_d,
    output logic                  dec_valid,
    output logic                  is_compressed,
    output op_e                   op,
    output logic [REG_ADDR_W-1:0] rd,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    output logic [XLEN-1:0]       imm,
    output logic                  jump_en,
    output logic [XLEN-1:0]       jump_offset
);

    // control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            jump_en   <= 1'b0;
            op        <= OP_ILLEGAL;
        end else begin
            dec_valid <= ins_valid;
            // a held result never redirects twice
            jump_en   <= ins_valid & jump_en_d;
            if (ins_valid) begin
                op <= op_d;
            end
        end
    end

    // payload, held between instructions
    always_ff @(posedge clk) begin
        if (ins_valid) begin
            is_compressed <= is_compressed_d;
            rd            <= rd_d;
            rs1           <= rs1_d;
            rs2           <= rs2_d;
            imm           <= imm_d;
            jump_offset   <= jump_offset_d;
        end
    end

endmodule

/* logic/imm_gen.sv */
module imm_gen import rv_decode_pkg::*; (
    input  logic [ILEN-1:0] ins,
    input  logic            is_compressed,
    output logic [XLEN-1:0] imm,
    output logic [XLEN-1:0] jump_offset
);

    opcode_e         opcode;
    quadrant_e       quad;
    logic [2:0]      c_funct3;
    logic [XLEN-1:0] std_imm;
    logic [XLEN-1:0] c_imm;
    logic [XLEN-1:0] ci_imm;
    logic [XLEN-1:0] cj_imm;
    logic            std_jump;
    logic            c_jump;
    logic            is_jump;

    assign opcode   = opcode_e'(ins[6:0]);
    assign quad     = quadrant_e'(ins[1:0]);
    assign c_funct3 = ins[15:13];

    // shared by c.j and c.jal
    assign cj_imm = {{20{ins[12]}}, ins[12], ins[8], ins[10:9], ins[6], ins[7],
                     ins[2], ins[11], ins[5:3], 1'b0};
    // six-bit signed CI field
    assign ci_imm = {{26{ins[12]}}, ins[12], ins[6:2]};

    assign std_jump = (opcode == OPC_JAL);
    assign c_jump   = (quad == Q1) && (c_funct3[1:0] == 2'b01);
    assign is_jump  = is_compressed ? c_jump : std_jump;

    assign imm         = is_compressed ? c_imm : std_imm;
    assign jump_offset = is_jump ? imm : '0;

    ////////////////////////////////////////////////////////////
    // standard formats
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC:
                std_imm = {ins[31:12], 12'b0};
            OPC_JAL:
                std_imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            OPC_JALR, OPC_LOAD, OPC_OP_IMM:
                std_imm = {{20{ins[31]}}, ins[31:20]};
            OPC_STORE:
                std_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            OPC_BRANCH:
                std_imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            default:
                std_imm = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // compressed formats
    ////////////////////////////////////////////////////////////
    always_comb begin
        c_imm = '0;
        case (quad)
            Q0: begin
                case (c_funct3)
                    // addi4spn, zero-extended nzuimm
                    3'b000:
                        c_imm = {22'b0, ins[10:7], ins[12:11], ins[5], ins[6], 2'b00};
                    3'b010, 3'b110:
                        c_imm = {25'b0, ins[5], ins[12:10], ins[6], 2'b00};
                    default:
                        c_imm = '0;
                endcase
            end
            Q1: begin
                case (c_funct3)
                    3'b000:
                        c_imm = ci_imm;
                    3'b001, 3'b101:
                        c_imm = cj_imm;
                    3'b011: begin
                        if (ins[11:7] == 5'd2)
                            c_imm = {{22{ins[12]}}, ins[12], ins[4:3], ins[5], ins[2],
                                     ins[6], 4'b0};
                        else
                            c_imm = {{14{ins[12]}}, ins[12], ins[6:2], 12'b0};
                    end
                    3'b100: begin
                        // andi signed, shifts take a plain shamt
                        case (ins[11:10])
                            2'b10:   c_imm = ci_imm;
                            2'b11:   c_imm = '0;
                            default: c_imm = {26'b0, ins[12], ins[6:2]};
                        endcase
                    end
                    3'b110, 3'b111:
                        c_imm = {{23{ins[12]}}, ins[12], ins[6:5], ins[2], ins[11:10],
                                 ins[4:3], 1'b0};
                    default:
                        c_imm = '0;
                endcase
            end
            Q2: begin
                case (c_funct3)
                    3'b000:  c_imm = {26'b0, ins[12], ins[6:2]};
                    3'b010:  c_imm = {24'b0, ins[3:2], ins[12], ins[6:4], 2'b00};
                    3'b110:  c_imm = {24'b0, ins[8:7], ins[12:9], 2'b00};
                    default: c_imm = '0;
                endcase
            end
            default: c_imm = '0;
        endcase
    end

endmodule

/* logic/op_decode.sv */
module op_decode import rv_decode_pkg::*; (
    input  logic [ILEN-1:0] ins,
    output logic            is_compressed,
    output op_e             op,
    output logic            jump_en
);

    quadrant_e  quad;
    opcode_e    opcode;
    logic [2:0] funct3;
    logic [2:0] c_funct3;
    logic       f7_alt;
    logic [4:0] c_rd;
    logic [4:0] c_rs2;
    op_e        std_op;
    op_e        c_op;
    op_e        c_alu_op;
    op_e        c_jr_op;

    assign quad          = quadrant_e'(ins[1:0]);
    assign is_compressed = (quad != Q_STD);
    assign opcode        = opcode_e'(ins[6:0]);
    assign funct3        = ins[14:12];
    assign f7_alt        = ins[30];
    assign c_funct3      = ins[15:13];
    assign c_rd          = ins[11:7];
    assign c_rs2         = ins[6:2];

    assign op = is_compressed ? c_op : std_op;
    // only JAL, C.J and C.JAL resolve their target here
    assign jump_en = (op == OP_JAL);

    ////////////////////////////////////////////////////////////
    // standard words
    ////////////////////////////////////////////////////////////
    always_comb begin
        std_op = OP_ILLEGAL;
        case (opcode)
            OPC_LUI:   std_op = OP_LUI;
            OPC_AUIPC: std_op = OP_AUIPC;
            OPC_JAL:   std_op = OP_JAL;
            OPC_JALR: begin
                if (funct3 == 3'b000)
                    std_op = OP_JALR;
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  std_op = OP_BEQ;
                    3'b001:  std_op = OP_BNE;
                    3'b100:  std_op = OP_BLT;
                    3'b101:  std_op = OP_BGE;
                    3'b110:  std_op = OP_BLTU;
                    3'b111:  std_op = OP_BGEU;
                    default: std_op = OP_ILLEGAL;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b000:  std_op = OP_LB;
                    3'b001:  std_op = OP_LH;
                    3'b010:  std_op = OP_LW;
                    3'b100:  std_op = OP_LBU;
                    3'b101:  std_op = OP_LHU;
                    default: std_op = OP_ILLEGAL;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000:  std_op = OP_SB;
                    3'b001:  std_op = OP_SH;
                    3'b010:  std_op = OP_SW;
                    default: std_op = OP_ILLEGAL;
                endcase
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b000: std_op = OP_ADDI;
                    3'b001: std_op = OP_SLLI;
                    3'b010: std_op = OP_SLTI;
                    3'b011: std_op = OP_SLTIU;
                    3'b100: std_op = OP_XORI;
                    3'b101: std_op = f7_alt ? OP_SRAI : OP_SRLI;
                    3'b110: std_op = OP_ORI;
                    3'b111: std_op = OP_ANDI;
                endcase
            end
            OPC_OP: begin
                case (funct3)
                    3'b000: std_op = f7_alt ? OP_SUB : OP_ADD;
                    3'b001: std_op = OP_SLL;
                    3'b010: std_op = OP_SLT;
                    3'b011: std_op = OP_SLTU;
                    3'b100: std_op = OP_XOR;
                    3'b101: std_op = f7_alt ? OP_SRA : OP_SRL;
                    3'b110: std_op = OP_OR;
                    3'b111: std_op = OP_AND;
                endcase
            end
            default: std_op = OP_ILLEGAL;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // compressed words
    ////////////////////////////////////////////////////////////
    // q1 funct3 100, shamt[5] must be 0 on rv32
    always_comb begin
        c_alu_op = OP_ILLEGAL;
        case (ins[11:10])
            2'b00: c_alu_op = ins[12] ? OP_ILLEGAL : OP_SRLI;
            2'b01: c_alu_op = ins[12] ? OP_ILLEGAL : OP_SRAI;
            2'b10: c_alu_op = OP_ANDI;
            2'b11: begin
                if (!ins[12]) begin
                    case (ins[6:5])
                        2'b00: c_alu_op = OP_SUB;
                        2'b01: c_alu_op = OP_XOR;
                        2'b10: c_alu_op = OP_OR;
                        2'b11: c_alu_op = OP_AND;
                    endcase
                end
            end
        endcase
    end

    // mv/add become add, jr/jalr become jalr
    always_comb begin
        if (c_rs2 != 5'd0)
            c_jr_op = OP_ADD;
        else if (c_rd == 5'd0)
            c_jr_op = OP_ILLEGAL;
        else
            c_jr_op = OP_JALR;
    end

    always_comb begin
        c_op = OP_ILLEGAL;
        case (quad)
            Q0: begin
                case (c_funct3)
                    3'b000: begin
                        if (ins[12:5] != 8'd0)
                            c_op = OP_ADDI;
                    end
                    3'b010:  c_op = OP_LW;
                    3'b110:  c_op = OP_SW;
                    default: c_op = OP_ILLEGAL;
                endcase
            end
            Q1: begin
                case (c_funct3)
                    3'b000: c_op = OP_ADDI;
                    3'b001: c_op = OP_JAL;
                    3'b011: begin
                        // zero immediate is reserved, rd x2 is addi16sp
                        if ({ins[12], ins[6:2]} == 6'd0)
                            c_op = OP_ILLEGAL;
                        else if (c_rd == 5'd2)
                            c_op = OP_ADDI;
                        else
                            c_op = OP_LUI;
                    end
                    3'b100:  c_op = c_alu_op;
                    3'b101:  c_op = OP_JAL;
                    3'b110:  c_op = OP_BEQ;
                    3'b111:  c_op = OP_BNE;
                    default: c_op = OP_ILLEGAL;
                endcase
            end
            Q2: begin
                case (c_funct3)
                    3'b000: begin
                        if (!ins[12])
                            c_op = OP_SLLI;
                    end
                    3'b010: begin
                        if (c_rd != 5'd0)
                            c_op = OP_LW;
                    end
                    3'b100:  c_op = c_jr_op;
                    3'b110:  c_op = OP_SW;
                    default: c_op = OP_ILLEGAL;
                endcase
            end
            default: c_op = OP_ILLEGAL;
        endcase
    end

endmodule

/* logic/reg_select.sv */
module reg_select import rv_decode_pkg::*; (
    input  logic [ILEN-1:0]       ins,
    input  logic                  is_compressed,
    output logic [REG_ADDR_W-1:0] rd,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2
);

    quadrant_e             quad;
    logic [2:0]            c_funct3;
    logic [REG_ADDR_W-1:0] rd_full;
    logic [REG_ADDR_W-1:0] rs2_full;
    logic [REG_ADDR_W-1:0] hi_prime;
    logic [REG_ADDR_W-1:0] lo_prime;

    assign quad     = quadrant_e'(ins[1:0]);
    assign c_funct3 = ins[15:13];
    assign rd_full  = ins[11:7];
    assign rs2_full = ins[6:2];
    // three-bit fields map onto x8..x15
    assign hi_prime = REG_ADDR_W'(CREG_BASE) + {2'b00, ins[9:7]};
    assign lo_prime = REG_ADDR_W'(CREG_BASE) + {2'b00, ins[4:2]};

    always_comb begin
        rd  = ins[11:7];
        rs1 = ins[19:15];
        rs2 = ins[24:20];
        if (is_compressed) begin
            rd  = rd_full;
            rs1 = rd_full;
            rs2 = rs2_full;
            case (quad)
                Q0: begin
                    rd  = lo_prime;
                    rs1 = (c_funct3 == 3'b000) ? 5'd2 : hi_prime;
                    rs2 = lo_prime;
                end
                Q1: begin
                    case (c_funct3)
                        3'b001: rd = 5'd1;
                        3'b100: begin
                            rd  = hi_prime;
                            rs1 = hi_prime;
                            rs2 = lo_prime;
                        end
                        3'b101: rd = 5'd0;
                        3'b110, 3'b111: begin
                            rd  = 5'd0;
                            rs1 = hi_prime;
                            rs2 = 5'd0;
                        end
                        default: rd = rd_full;
                    endcase
                end
                Q2: begin
                    case (c_funct3)
                        3'b010, 3'b110: rs1 = 5'd2;
                        3'b100: begin
                            // jr links to x0, jalr to x1
                            if (rs2_full == 5'd0)
                                rd = REG_ADDR_W'(ins[12]);
                            else if (!ins[12])
                                rs1 = 5'd0;
                        end
                        default: rs1 = rd_full;
                    endcase
                end
                default: rd = rd_full;
            endcase
        end
    end

endmodule

/* logic/rv32c_decoder.sv */
module rv32c_decoder import rv_decode_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ins_valid,
    input  logic [ILEN-1:0]       ins,
    output logic                  dec_valid,
    output op_e                   op,
    output logic [REG_ADDR_W-1:0] rd,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    output logic [XLEN-1:0]       imm,
    output logic                  jump_en,
    output logic [XLEN-1:0]       jump_offset,
    output logic                  is_compressed
);

    logic                  is_compressed_d;
    op_e                   op_d;
    logic                  jump_en_d;
    logic [REG_ADDR_W-1:0] rd_d;
    logic [REG_ADDR_W-1:0] rs1_d;
    logic [REG_ADDR_W-1:0] rs2_d;
    logic [XLEN-1:0]       imm_d;
    logic [XLEN-1:0]       jump_offset_d;

    ////////////////////////////////////////////////////////////
    // combinational decode
    ////////////////////////////////////////////////////////////
    op_decode u_op_decode (
        .ins           (ins),
        .is_compressed (is_compressed_d),
        .op            (op_d),
        .jump_en       (jump_en_d)
    );

    reg_select u_reg_select (
        .ins           (ins),
        .is_compressed (is_compressed_d),
        .rd            (rd_d),
        .rs1           (rs1_d),
        .rs2           (rs2_d)
    );

    imm_gen u_imm_gen (
        .ins           (ins),
        .is_compressed (is_compressed_d),
        .imm           (imm_d),
        .jump_offset   (jump_offset_d)
    );

    ////////////////////////////////////////////////////////////
    // stage register
    ////////////////////////////////////////////////////////////
    decode_reg u_decode_reg (
        .clk             (clk),
        .rst_n           (rst_n),
        .ins_valid       (ins_valid),
        .is_compressed_d (is_compressed_d),
        .op_d            (op_d),
        .rd_d            (rd_d),
        .rs1_d           (rs1_d),
        .rs2_d           (rs2_d),
        .imm_d           (imm_d),
        .jump_en_d       (jump_en_d),
        .jump_offset_d   (jump_offset_d),
        .dec_valid       (dec_valid),
        .is_compressed   (is_compressed),
        .op              (op),
        .rd              (rd),
        .rs1             (rs1),
        .rs2             (rs2),
        .imm             (imm),
        .jump_en         (jump_en),
        .jump_offset     (jump_offset)
    );

endmodule

/* logic/rv_decode_pkg.sv */
package rv_decode_pkg;

    localparam int XLEN       = 32;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    // first of the x8..x15 prime registers
    localparam int CREG_BASE  = 8;

    // standard major opcodes
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // low two bits, 2'b11 marks a 32-bit word
    typedef enum logic [1:0] {
        Q0    = 2'b00,
        Q1    = 2'b01,
        Q2    = 2'b10,
        Q_STD = 2'b11
    } quadrant_e;

    typedef enum logic [5:0] {
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_ADDI,
        OP_SLTI,
        OP_SLTIU,
        OP_XORI,
        OP_ORI,
        OP_ANDI,
        OP_SLLI,
        OP_SRLI,
        OP_SRAI,
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        OP_ILLEGAL
    } op_e;

endpackage

/* rv32c_decoder.f */
logic/rv_decode_pkg.sv
logic/op_decode.sv
logic/imm_gen.sv
logic/reg_select.sv
logic/decode_reg.sv
logic/rv32c_decoder.sv
tb/rv32c_decoder_asserts.sv
tb/tb_rv32c_decoder.sv

/* tb/rv32c_decoder_asserts.sv */
module rv32c_decoder_asserts import rv_decode_pkg::*; (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  ins_valid,
    input logic [ILEN-1:0]       ins,
    input logic                  dec_valid,
    input op_e                   op,
    input logic [REG_ADDR_W-1:0] rd,
    input logic [REG_ADDR_W-1:0] rs1,
    input logic [REG_ADDR_W-1:0] rs2,
    input logic [XLEN-1:0]       imm,
    input logic                  jump_en,
    input logic [XLEN-1:0]       jump_offset,
    input logic                  is_compressed
);

    int fail_count = 0;

    task automatic report_failure(input string msg);
        fail_count++;
        $error("error at %0t: %s", $time, msg);
    endtask

    ////////////////////////////////////////////////////////////
    // reference rules from the ISA
    ////////////////////////////////////////////////////////////
    // R-type and I-type words keep the fixed fields
    function automatic logic is_std_reg_form(logic [ILEN-1:0] w);
        return w[6:0] == OPC_OP || w[6:0] == OPC_OP_IMM ||
               w[6:0] == OPC_LOAD || w[6:0] == OPC_JALR;
    endfunction

    // c.sub/xor/or/and group
    function automatic logic is_ca_form(logic [ILEN-1:0] w);
        return w[1:0] == 2'b01 && w[15:13] == 3'b100 && w[11:10] == 2'b11;
    endfunction

    // jal, c.jal and c.j
    function automatic logic direct_jump_form(logic [ILEN-1:0] w);
        if (w[1:0] == 2'b11)
            return w[6:0] == OPC_JAL;
        else
            return w[1:0] == 2'b01 && (w[15:13] == 3'b001 || w[15:13] == 3'b101);
    endfunction

    function automatic logic in_prime_range(logic [REG_ADDR_W-1:0] r);
        return r >= REG_ADDR_W'(CREG_BASE) && r <= REG_ADDR_W'(CREG_BASE + 7);
    endfunction

    function automatic op_e expected_alu_op(logic [ILEN-1:0] w);
        op_e  res;
        logic alt;
        alt = w[30];
        if (w[6:0] == OPC_OP) begin
            case (w[14:12])
                3'b000:  res = alt ? OP_SUB : OP_ADD;
                3'b001:  res = OP_SLL;
                3'b010:  res = OP_SLT;
                3'b011:  res = OP_SLTU;
                3'b100:  res = OP_XOR;
                3'b101:  res = alt ? OP_SRA : OP_SRL;
                3'b110:  res = OP_OR;
                default: res = OP_AND;
            endcase
        end else begin
            case (w[14:12])
                3'b000:  res = OP_ADDI;
                3'b001:  res = OP_SLLI;
                3'b010:  res = OP_SLTI;
                3'b011:  res = OP_SLTIU;
                3'b100:  res = OP_XORI;
                3'b101:  res = alt ? OP_SRAI : OP_SRLI;
                3'b110:  res = OP_ORI;
                default: res = OP_ANDI;
            endcase
        end
        return res;
    endfunction

    // a subset of the reserved or unsupported encodings
    function automatic logic is_illegal(logic [ILEN-1:0] w);
        logic [2:0] f3;
        logic [2:0] c3;
        f3 = w[14:12];
        c3 = w[15:13];
        case (w[1:0])
            2'b00: return (c3 == 3'b000 && w[12:5] == 8'd0) ||
                          c3 inside {3'b001, 3'b011, 3'b100, 3'b101, 3'b111};
            2'b01: return c3 == 3'b100 && w[12:10] == 3'b111;
            2'b10: return c3 inside {3'b001, 3'b011, 3'b101, 3'b111} ||
                          w[15:0] == 16'h8002;
            default: begin
                case (w[6:0])
                    OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_OP_IMM, OPC_OP: return 1'b0;
                    OPC_JALR:   return f3 != 3'b000;
                    OPC_BRANCH: return f3 inside {3'b010, 3'b011};
                    OPC_LOAD:   return f3 inside {3'b011, 3'b110, 3'b111};
                    OPC_STORE:  return f3 > 3'b010;
                    default:    return 1'b1;
                endcase
            end
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////
    a_reset_values: assert property (@(posedge clk)
        !rst_n |=> !dec_valid && !jump_en && op == OP_ILLEGAL)
        else report_failure("outputs not cleared by reset");

    a_valid_delay: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid == $past(ins_valid))
        else report_failure("dec_valid does not follow ins_valid by one cycle");

    a_compressed: assert property (@(posedge clk) disable iff (!rst_n)
        $past(ins_valid) |-> is_compressed == ($past(ins[1:0]) != 2'b11))
        else report_failure("is_compressed wrong for the low two bits");

    a_std_regs: assert property (@(posedge clk) disable iff (!rst_n)
        $past(ins_valid) && is_std_reg_form($past(ins)) |->
            rd == $past(ins[11:7]) && rs1 == $past(ins[19:15]) &&
            rs2 == $past(ins[24:20]))
        else report_failure("register fields of a standard word");

    a_prime_regs: assert property (@(posedge clk) disable iff (!rst_n)
        $past(ins_valid) && is_ca_form($past(ins)) |->
            in_prime_range(rd) && in_prime_range(rs2))
        else report_failure("compressed arithmetic register outside x8..x15");

    a_alu_op: assert property (@(posedge clk) disable iff (!rst_n)
        $past(ins_valid) &&
        ($past(ins[6:0]) == OPC_OP || $past(ins[6:0]) == OPC_OP_IMM) |->
            op == expected_alu_op($past(ins)))
        else report_failure("operation of an OP or OP-IMM word");

    a_lui_imm: assert property (@(posedge clk) disable iff (!rst_n)
        $past(ins_valid) && $past(ins[6:0]) == OPC_LUI |->
            imm == {$past(ins[31:12]), 12'b0})
        else report_failure("LUI immediate");

    a_jump_flag: assert property (@(posedge clk) disable iff (!rst_n)
        jump_en == ($past(ins_valid) && direct_jump_form($past(ins))) &&
        jump_en == (dec_valid && op == OP_JAL))
        else report_failure("jump_en does not match a fresh direct jump as OP_JAL");

    a_jump_offset: assert property (@(posedge clk) disable iff (!rst_n)
        jump_en |-> jump_offset == imm && !imm[0])
        else report_failure("jump offset differs from the immediate");

    a_illegal: assert property (@(posedge clk) disable iff (!rst_n)
        $past(ins_valid) && is_illegal($past(ins)) |-> op == OP_ILLEGAL && !jump_en)
        else report_failure("reserved encoding not decoded as OP_ILLEGAL");

endmodule

/* tb/tb_rv32c_decoder.sv */
module tb_rv32c_decoder import rv_decode_pkg::*; ();

    logic                  clk;
    logic                  rst_n;
    logic                  ins_valid;
    logic [ILEN-1:0]       ins;
    logic                  dec_valid;
    op_e                   op;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm;
    logic                  jump_en;
    logic [XLEN-1:0]       jump_offset;
    logic                  is_compressed;

    rv32c_decoder UUT (.*);

    bind rv32c_decoder rv32c_decoder_asserts u_asserts (.*);

    always #2 clk = ~clk;

    // stop at the first assertion failure
    always @(negedge clk) begin
        if (UUT.u_asserts.fail_count != 0) begin
            $display("Simulation failed");
            $fatal(1, "a decoder assertion failed");
        end
    end

    function automatic logic [ILEN-1:0] encode_r(logic [6:0] funct7, logic [2:0] funct3,
                                                 opcode_e opc);
        return {funct7, 5'd3, 5'd2, funct3, 5'd1, opc};
    endfunction

    task automatic send_word(input logic [ILEN-1:0] word);
        @(posedge clk);
        ins_valid <= 1'b1;
        ins       <= word;
    endtask

    task automatic wait_result();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!dec_valid && cycles < 8) begin
            @(negedge clk);
            cycles++;
        end
        if (!dec_valid) begin
            $display("timeout: no decode result %0d cycles after the last word", cycles);
            $display("Simulation failed");
            $fatal(1, "decoder result timeout");
        end
    endtask

    // drop the strobe and see the last word come out
    task automatic end_burst();
        @(posedge clk);
        ins_valid <= 1'b0;
        wait_result();
    endtask

    initial begin
        logic [ILEN-1:0] directed [0:55];
        logic [ILEN-1:0] word;
        int              i;
        int              f3;
        int              alt;

        clk       = 1'b0;
        rst_n     = 1'b0;
        ins_valid = 1'b0;
        ins       = '0;
        void'($urandom(32'h5021f7fc));

        // standard, then compressed, then reserved encodings
        directed = '{
            32'h123452B7, 32'h00001097, 32'hFFDFF0EF, 32'h000080E7,
            32'h00208463, 32'h00209463, 32'h0020C463, 32'h0020D463,
            32'h0020E463, 32'h0020F463, 32'h00410183, 32'h00411183,
            32'h00412183, 32'h00414183, 32'h00415183, 32'h00310423,
            32'h00311423, 32'h00312423, 32'h00000040, 32'h00004144,
            32'h0000C144, 32'h00002011, 32'h00003FFD, 32'h0000157D,
            32'h00006285, 32'h00006141, 32'h00008005, 32'h00008405,
            32'h00008805, 32'h00008C05, 32'h00008C25, 32'h00008C45,
            32'h00008C65, 32'h0000A011, 32'h0000BFFD, 32'h0000C011,
            32'h0000E011, 32'h00000086, 32'h00004092, 32'h00008082,
            32'h0000808A, 32'h00009082, 32'h0000908A, 32'h0000C006,
            32'h00000000, 32'h00002000, 32'h00008000, 32'h00009C01,
            32'h00002002, 32'h00008002, 32'hFFFFFFFF, 32'h00003003,
            32'h0000207F, 32'h00002067, 32'h0000A063, 32'h00003023
        };

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // bursts of four back-to-back words
        for (i = 0; i < $size(directed); i++) begin
            send_word(directed[i]);
            if (i % 4 == 3)
                end_burst();
        end

        // full funct3 table, funct7 bit 5 both ways
        for (f3 = 0; f3 < 8; f3++) begin
            for (alt = 0; alt < 2; alt++) begin
                send_word(encode_r((alt != 0) ? 7'h20 : 7'h00, 3'(f3), OPC_OP));
                send_word(encode_r((alt != 0) ? 7'h20 : 7'h00, 3'(f3), OPC_OP_IMM));
            end
            end_burst();
        end

        for (i = 0; i < 400; i++) begin
            word = $urandom();
            send_word(word);
            if ($urandom_range(3, 0) == 0)
                end_burst();
        end
        end_burst();

        repeat (2) @(negedge clk);
        if (UUT.u_asserts.fail_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "decoder assertions reported failures");
        end
    end

endmodule
